// File: src/dma_chn_pkg.sv
// DMA channel shared types
package dma_chn_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [1:0]  tr_width_t;
  typedef logic [1:0]  inc_mode_t;
  typedef logic [2:0]  hsize_t;
  typedef logic [1:0]  lane_t;

  // Transfer width codes share the bus size encoding.
  localparam tr_width_t WIDTH_BYTE = 2'd0;
  localparam tr_width_t WIDTH_HALF = 2'd1;
  localparam tr_width_t WIDTH_WORD = 2'd2;

  // Address modes. Codes 2 and 3 keep the address fixed.
  localparam inc_mode_t INC_UP   = 2'd0;
  localparam inc_mode_t INC_DOWN = 2'd1;

  // Bytes moved by one element of the given width.
  function automatic logic [2:0] tr_bytes(input tr_width_t width);
    logic [2:0] n;
    case (width)
      WIDTH_BYTE: n = 3'd1;
      WIDTH_HALF: n = 3'd2;
      default:    n = 3'd4;
    endcase
    return n;
  endfunction

endpackage

// File: src/chn_bus_fsm.sv
// Channel bus phase FSM
`timescale 1ns/10ps

module chn_bus_fsm (
  input  logic                   hclk,
  input  logic                   hrst_n,
  input  logic                   chn_en_i,
  input  logic                   grant_i,
  input  logic                   hready_i,
  input  dma_chn_pkg::tr_width_t src_width_i,
  input  dma_chn_pkg::tr_width_t dst_width_i,
  input  logic                   blk_last_i,
  output logic                   busy_o,
  output logic                   accept_o,
  output logic                   rd_phase_o,
  output logic                   idle_o,
  output logic                   last_rd_o,
  output logic                   last_wr_o
);
  import dma_chn_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_MORE,
    ST_RD_LAST,
    ST_WR_MORE,
    ST_WR_LAST
  } state_t;

  state_t     state_q;
  state_t     state_d;
  state_t     rd_entry;
  state_t     wr_entry;
  logic [2:0] src_bytes;
  logic [2:0] dst_bytes;
  logic [2:0] rd_cnt_q;
  logic [2:0] wr_cnt_q;

  assign src_bytes = tr_bytes(src_width_i);
  assign dst_bytes = tr_bytes(dst_width_i);

  // A single read fills the buffer when the source is at least as wide.
  assign rd_entry = (src_bytes >= dst_bytes) ? ST_RD_LAST : ST_RD_MORE;
  assign wr_entry = (dst_bytes >= src_bytes) ? ST_WR_LAST : ST_WR_MORE;

  assign idle_o     = (state_q == ST_IDLE);
  assign last_rd_o  = (state_q == ST_RD_LAST);
  assign last_wr_o  = (state_q == ST_WR_LAST);
  assign rd_phase_o = (state_q == ST_RD_MORE) || last_rd_o;
  assign busy_o     = !idle_o && grant_i;
  assign accept_o   = busy_o && hready_i;

  always_comb begin
    state_d = state_q;
    if (hready_i) begin // Wait states hold everything.
      if (!chn_en_i) begin
        state_d = ST_IDLE;
      end else begin
        case (state_q)
          ST_IDLE: begin
            if (grant_i) state_d = rd_entry;
          end
          ST_RD_MORE: begin
            if (accept_o && (rd_cnt_q == src_bytes)) state_d = ST_RD_LAST;
          end
          ST_RD_LAST: begin
            if (accept_o) state_d = wr_entry;
          end
          ST_WR_MORE: begin
            if (accept_o && blk_last_i) begin
              state_d = ST_IDLE;
            end else if (accept_o && (wr_cnt_q == dst_bytes)) begin
              state_d = ST_WR_LAST;
            end
          end
          ST_WR_LAST: begin
            if (accept_o) state_d = blk_last_i ? ST_IDLE : rd_entry;
          end
          default: state_d = ST_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      state_q  <= ST_IDLE;
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // Ratio counters reload outside their own multi-beat state.
      if (state_q != ST_RD_MORE) begin
        rd_cnt_q <= dst_bytes - src_bytes;
      end else if (accept_o) begin
        rd_cnt_q <= rd_cnt_q - src_bytes;
      end
      if (state_q != ST_WR_MORE) begin
        wr_cnt_q <= src_bytes - dst_bytes;
      end else if (accept_o) begin
        wr_cnt_q <= wr_cnt_q - dst_bytes;
      end
    end
  end

  // Ratio counters never step past the final beat of their state.
  a_rd_ratio: assert property (@(posedge hclk) disable iff (!hrst_n)
    (state_q == ST_RD_MORE) |-> (rd_cnt_q >= src_bytes));

  a_wr_ratio: assert property (@(posedge hclk) disable iff (!hrst_n)
    (state_q == ST_WR_MORE) |-> (wr_cnt_q >= dst_bytes));

endmodule

// File: src/chn_addr_gen.sv
// Source and destination address generator
`timescale 1ns/10ps

module chn_addr_gen (
  input  logic                   hclk,
  input  logic                   hrst_n,
  input  dma_chn_pkg::addr_t     sar_i,
  input  dma_chn_pkg::addr_t     dar_i,
  input  dma_chn_pkg::tr_width_t src_width_i,
  input  dma_chn_pkg::tr_width_t dst_width_i,
  input  dma_chn_pkg::inc_mode_t sinc_i,
  input  dma_chn_pkg::inc_mode_t dinc_i,
  input  logic                   accept_i,
  input  logic                   rd_phase_i,
  input  logic                   idle_i,
  output dma_chn_pkg::addr_t     haddr_o,
  output dma_chn_pkg::hsize_t    hsize_o,
  output logic                   hwrite_o
);
  import dma_chn_pkg::*;

  addr_t     src_q;
  addr_t     dst_q;
  tr_width_t cur_width;

  // Clear the low bits below the element size.
  function automatic addr_t align_addr(input addr_t addr, input tr_width_t width);
    addr_t res;
    case (width)
      WIDTH_BYTE: res = addr;
      WIDTH_HALF: res = {addr[31:1], 1'b0};
      default:    res = {addr[31:2], 2'b00};
    endcase
    return res;
  endfunction

  function automatic addr_t step_addr(input addr_t addr, input inc_mode_t mode,
                                      input tr_width_t width);
    addr_t res;
    case (mode)
      INC_UP:   res = addr + addr_t'(tr_bytes(width));
      INC_DOWN: res = addr - addr_t'(tr_bytes(width));
      default:  res = addr; // Fixed.
    endcase
    return res;
  endfunction

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      src_q <= '0;
      dst_q <= '0;
    end else if (idle_i) begin
      src_q <= align_addr(sar_i, src_width_i);
      dst_q <= align_addr(dar_i, dst_width_i);
    end else if (accept_i) begin
      if (rd_phase_i) src_q <= step_addr(src_q, sinc_i, src_width_i);
      else            dst_q <= step_addr(dst_q, dinc_i, dst_width_i);
    end
  end

  assign cur_width = rd_phase_i ? src_width_i : dst_width_i;
  assign haddr_o   = rd_phase_i ? src_q : dst_q;
  assign hsize_o   = {1'b0, cur_width};
  assign hwrite_o  = !rd_phase_i && !idle_i;

  // Addresses stay aligned through every step of the block.
  a_addr_aligned: assert property (@(posedge hclk) disable iff (!hrst_n)
    !idle_i |-> ((haddr_o[1:0] & lane_t'(tr_bytes(hsize_o[1:0]) - 3'd1)) == 2'b00));

endmodule

// File: src/chn_data_pack.sv
// Read pack and write unpack datapath
`timescale 1ns/10ps

module chn_data_pack (
  input  logic                   hclk,
  input  logic                   hrst_n,
  input  dma_chn_pkg::data_t     hrdata_i,
  input  logic                   hready_i,
  input  dma_chn_pkg::lane_t     cur_lane_i,
  input  logic                   accept_i,
  input  logic                   rd_phase_i,
  input  dma_chn_pkg::tr_width_t src_width_i,
  input  dma_chn_pkg::tr_width_t dst_width_i,
  output dma_chn_pkg::data_t     hwdata_o
);
  import dma_chn_pkg::*;

  lane_t      lane_q;
  logic       rd_pend_q;
  logic       wr_pend_q;
  logic       rd_dph;
  logic       wr_dph;
  logic [2:0] rd_ptr_q;
  logic [2:0] wr_ptr_q;
  data_t      src_mask;
  data_t      dst_mask;
  data_t      rd_elem;
  data_t      wr_elem;
  data_t      buf_q;
  data_t      buf_d;

  function automatic data_t width_mask(input tr_width_t width);
    data_t m;
    case (width)
      WIDTH_BYTE: m = 32'h0000_00ff;
      WIDTH_HALF: m = 32'h0000_ffff;
      default:    m = 32'hffff_ffff;
    endcase
    return m;
  endfunction

  assign src_mask = width_mask(src_width_i);
  assign dst_mask = width_mask(dst_width_i);

  assign rd_dph = rd_pend_q && hready_i;
  assign wr_dph = wr_pend_q && hready_i;

  // Element down to bit 0, then into the next free buffer bytes.
  assign rd_elem = (hrdata_i >> {lane_q, 3'b000}) & src_mask;
  assign buf_d   = (buf_q & ~(src_mask << {rd_ptr_q[1:0], 3'b000}))
                 | (rd_elem << {rd_ptr_q[1:0], 3'b000});

  assign wr_elem  = (buf_q >> {wr_ptr_q[1:0], 3'b000}) & dst_mask;
  assign hwdata_o = wr_elem << {lane_q, 3'b000}; // Lanes of the write address.

  always_ff @(posedge hclk) begin
    if (accept_i) lane_q <= cur_lane_i;
    if (rd_dph)   buf_q  <= buf_d;
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
      rd_ptr_q  <= '0;
      wr_ptr_q  <= '0;
    end else begin
      if (accept_i && rd_phase_i) rd_pend_q <= 1'b1;
      else if (hready_i)          rd_pend_q <= 1'b0;
      if (accept_i && !rd_phase_i) wr_pend_q <= 1'b1;
      else if (hready_i)           wr_pend_q <= 1'b0;
      // Fill restarts after a drain and drain restarts after a fill.
      if (wr_dph) begin
        rd_ptr_q <= '0;
      end else if (rd_dph) begin
        rd_ptr_q <= rd_ptr_q + tr_bytes(src_width_i);
      end
      if (rd_dph) begin
        wr_ptr_q <= '0;
      end else if (wr_dph) begin
        wr_ptr_q <= wr_ptr_q + tr_bytes(dst_width_i);
      end
    end
  end

  // FSM read and write counts must match the buffer size.
  a_pack_bound: assert property (@(posedge hclk) disable iff (!hrst_n)
    (rd_ptr_q <= 3'd4) && (wr_ptr_q <= 3'd4));

endmodule

// File: src/chn_block_cntr.sv
// Block byte counter and status pulses
`timescale 1ns/10ps

module chn_block_cntr #(
  parameter int BLK_W = 12
) (
  input  logic                   hclk,
  input  logic                   hrst_n,
  input  logic [BLK_W-1:0]       block_tl_i,
  input  dma_chn_pkg::tr_width_t dst_width_i,
  input  logic                   accept_i,
  input  logic                   rd_phase_i,
  input  logic                   idle_i,
  input  logic                   hready_i,
  input  logic                   hresp_i,
  output logic                   blk_last_o,
  output logic                   done_o,
  output logic                   half_done_o,
  output logic                   err_o
);
  import dma_chn_pkg::*;

  localparam int CW = BLK_W + 1;

  logic [CW-1:0] blk_len;
  logic [CW-1:0] half_len;
  logic [CW-1:0] dst_step;
  logic [CW-1:0] cnt_q;
  logic          wr_acc;
  logic          end_pend_q;
  logic          dph_pend_q;
  logic          half_lvl;
  logic          half_d_q;

  assign blk_len  = CW'(block_tl_i) + CW'(1);
  assign half_len = blk_len >> 1;
  assign dst_step = CW'(tr_bytes(dst_width_i));
  assign wr_acc   = accept_i && !rd_phase_i;

  assign blk_last_o  = (cnt_q == '0);
  assign half_lvl    = !idle_i && (cnt_q < half_len);
  assign half_done_o = half_lvl && !half_d_q; // Rising edge only.
  assign done_o      = end_pend_q && hready_i;
  assign err_o       = dph_pend_q && hready_i && hresp_i;

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      cnt_q      <= '0;
      end_pend_q <= 1'b0;
      dph_pend_q <= 1'b0;
      half_d_q   <= 1'b0;
    end else begin
      if (idle_i) begin
        cnt_q <= blk_len - dst_step;
      end else if (wr_acc && !blk_last_o) begin
        cnt_q <= cnt_q - dst_step;
      end
      if (wr_acc && blk_last_o) end_pend_q <= 1'b1;
      else if (hready_i)        end_pend_q <= 1'b0;
      if (accept_i)      dph_pend_q <= 1'b1;
      else if (hready_i) dph_pend_q <= 1'b0;
      half_d_q <= half_lvl;
    end
  end

endmodule

// File: src/dma_chn_top.sv
// DMA channel top level
`timescale 1ns/10ps

module dma_chn_top #(
  parameter int BLK_W = 12
) (
  input  logic                   hclk,
  input  logic                   hrst_n,
  // Channel configuration.
  input  logic                   chn_en_i,
  input  dma_chn_pkg::addr_t     sar_i,
  input  dma_chn_pkg::addr_t     dar_i,
  input  logic [BLK_W-1:0]       block_tl_i,
  input  dma_chn_pkg::tr_width_t src_width_i,
  input  dma_chn_pkg::tr_width_t dst_width_i,
  input  dma_chn_pkg::inc_mode_t sinc_i,
  input  dma_chn_pkg::inc_mode_t dinc_i,
  input  logic                   grant_i,
  // AHB-Lite master.
  output dma_chn_pkg::addr_t     haddr_o,
  output dma_chn_pkg::hsize_t    hsize_o,
  output logic                   hwrite_o,
  output logic                   htrans_o,
  output dma_chn_pkg::data_t     hwdata_o,
  input  dma_chn_pkg::data_t     hrdata_i,
  input  logic                   hready_i,
  input  logic                   hresp_i,
  // Status pulses.
  output logic                   done_o,
  output logic                   half_done_o,
  output logic                   err_o
);
  import dma_chn_pkg::*;

  logic  accept;
  logic  rd_phase;
  logic  fsm_idle;
  logic  blk_last;
  lane_t cur_lane;

  assign cur_lane = haddr_o[1:0];

  chn_bus_fsm u_fsm (
    .hclk        (hclk),
    .hrst_n      (hrst_n),
    .chn_en_i    (chn_en_i),
    .grant_i     (grant_i),
    .hready_i    (hready_i),
    .src_width_i (src_width_i),
    .dst_width_i (dst_width_i),
    .blk_last_i  (blk_last),
    .busy_o      (htrans_o),
    .accept_o    (accept),
    .rd_phase_o  (rd_phase),
    .idle_o      (fsm_idle),
    .last_rd_o   (),
    .last_wr_o   ()
  );

  chn_addr_gen u_addr (
    .hclk        (hclk),
    .hrst_n      (hrst_n),
    .sar_i       (sar_i),
    .dar_i       (dar_i),
    .src_width_i (src_width_i),
    .dst_width_i (dst_width_i),
    .sinc_i      (sinc_i),
    .dinc_i      (dinc_i),
    .accept_i    (accept),
    .rd_phase_i  (rd_phase),
    .idle_i      (fsm_idle),
    .haddr_o     (haddr_o),
    .hsize_o     (hsize_o),
    .hwrite_o    (hwrite_o)
  );

  chn_data_pack u_pack (
    .hclk        (hclk),
    .hrst_n      (hrst_n),
    .hrdata_i    (hrdata_i),
    .hready_i    (hready_i),
    .cur_lane_i  (cur_lane),
    .accept_i    (accept),
    .rd_phase_i  (rd_phase),
    .src_width_i (src_width_i),
    .dst_width_i (dst_width_i),
    .hwdata_o    (hwdata_o)
  );

  chn_block_cntr #(
    .BLK_W (BLK_W)
  ) u_blk (
    .hclk        (hclk),
    .hrst_n      (hrst_n),
    .block_tl_i  (block_tl_i),
    .dst_width_i (dst_width_i),
    .accept_i    (accept),
    .rd_phase_i  (rd_phase),
    .idle_i      (fsm_idle),
    .hready_i    (hready_i),
    .hresp_i     (hresp_i),
    .blk_last_o  (blk_last),
    .done_o      (done_o),
    .half_done_o (half_done_o),
    .err_o       (err_o)
  );

endmodule

// File: verification/ahb_mem_model.sv
// AHB-Lite slave memory model
`timescale 1ns/10ps

module ahb_mem_model (
  input  logic        hclk,
  input  logic        hrst_n,
  input  logic [31:0] haddr_i,
  input  logic [2:0]  hsize_i,
  input  logic        hwrite_i,
  input  logic        htrans_i,
  input  logic [31:0] hwdata_i,
  input  logic        err_en_i,
  input  logic [31:0] err_addr_i,
  output logic [31:0] hrdata_o,
  output logic        hready_o,
  output logic        hresp_o
);
  logic [7:0] mem [0:1023];
  logic       pend_q;
  logic       write_q;
  logic [9:0] addr_q;
  logic [2:0] size_q;

  // Little endian lanes with byte k of the word on bits 8k+7..8k.
  assign hrdata_o = {mem[{addr_q[9:2], 2'd3}], mem[{addr_q[9:2], 2'd2}],
                     mem[{addr_q[9:2], 2'd1}], mem[{addr_q[9:2], 2'd0}]};
  assign hresp_o  = pend_q && err_en_i && (addr_q == err_addr_i[9:0]);

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      pend_q   <= 1'b0;
      write_q  <= 1'b0;
      addr_q   <= '0;
      size_q   <= '0;
      hready_o <= 1'b1;
    end else begin
      hready_o <= ($urandom_range(3) != 0); // About one wait in four.
      if (hready_o) begin
        pend_q <= htrans_i;
        if (htrans_i) begin
          addr_q  <= haddr_i[9:0];
          write_q <= hwrite_i;
          size_q  <= hsize_i;
        end
      end
    end
  end

  // Write data phase.
  always @(posedge hclk) begin
    int lo;
    int nb;
    lo = int'(addr_q[1:0]);
    nb = 1 << size_q;
    if (pend_q && hready_o && write_q) begin
      for (int k = 0; k < 4; k++) begin
        if (k >= lo && k < lo + nb) mem[{addr_q[9:2], 2'(k)}] = hwdata_i[8*k +: 8];
      end
    end
  end

endmodule

// File: verification/tb_dma_chn.sv
// DMA channel testbench
`timescale 1ns/10ps

module tb_dma_chn;
  localparam int BLK_W       = 12;
  localparam int TOTAL_BYTES = 184; // Sum of all block lengths below.
  localparam int CYC_PER_B   = 40;  // Read and write per byte, waits and grant gaps.
  localparam int WD_CYCLES   = TOTAL_BYTES * CYC_PER_B + 1000;

  logic             hclk;
  logic             hrst_n;
  logic             chn_en;
  logic [31:0]      sar;
  logic [31:0]      dar;
  logic [BLK_W-1:0] block_tl;
  logic [1:0]       src_w;
  logic [1:0]       dst_w;
  logic [1:0]       sinc;
  logic [1:0]       dinc;
  logic             grant;
  logic [31:0]      haddr;
  logic [2:0]       hsize;
  logic             hwrite;
  logic             htrans;
  logic [31:0]      hwdata;
  logic [31:0]      hrdata;
  logic             hready;
  logic             hresp;
  logic             done;
  logic             half_done;
  logic             err;
  logic             err_en;
  logic             clr_cnt;
  int               wr_idx;
  int               half_cnt;
  int               done_cnt;
  int               err_cnt;
  logic [31:0]      exp_waddr;
  logic [7:0]       exp_mem [0:1023];
  logic [7:0]       stream [0:255];

  dma_chn_top #(.BLK_W(BLK_W)) uut (
    .hclk(hclk), .hrst_n(hrst_n), .chn_en_i(chn_en), .sar_i(sar), .dar_i(dar),
    .block_tl_i(block_tl), .src_width_i(src_w), .dst_width_i(dst_w),
    .sinc_i(sinc), .dinc_i(dinc), .grant_i(grant), .haddr_o(haddr),
    .hsize_o(hsize), .hwrite_o(hwrite), .htrans_o(htrans), .hwdata_o(hwdata),
    .hrdata_i(hrdata), .hready_i(hready), .hresp_i(hresp), .done_o(done),
    .half_done_o(half_done), .err_o(err)
  );

  ahb_mem_model mem_i (
    .hclk(hclk), .hrst_n(hrst_n), .haddr_i(haddr), .hsize_i(hsize),
    .hwrite_i(hwrite), .htrans_i(htrans), .hwdata_i(hwdata),
    .err_en_i(err_en), .err_addr_i(32'h0000_0008), .hrdata_o(hrdata),
    .hready_o(hready), .hresp_o(hresp)
  );

  always #5 hclk = ~hclk;

  function automatic int width_bytes(input logic [1:0] w);
    return 1 << w;
  endfunction

  // Address of element idx from an aligned-down start.
  function automatic logic [31:0] elem_addr(input logic [31:0] start, input int nb,
                                            input logic [1:0] mode, input int idx);
    logic [31:0] base;
    logic [31:0] res;
    base = start & ~(32'(nb) - 32'd1);
    case (mode)
      2'd0:    res = base + 32'(idx * nb);
      2'd1:    res = base - 32'(idx * nb);
      default: res = base;
    endcase
    return res;
  endfunction

  function automatic logic [7:0] src_byte(input int a);
    return 8'((a * 13) ^ (a >> 5) ^ 8'h5a);
  endfunction

  task automatic value_error(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic fail_with(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  assign exp_waddr = elem_addr(dar, width_bytes(dst_w), dinc, wr_idx);

  always @(posedge hclk) begin
    if (clr_cnt) begin
      wr_idx   <= 0;
      half_cnt <= 0;
      done_cnt <= 0;
      err_cnt  <= 0;
    end else begin
      if (htrans && hready && hwrite) wr_idx <= wr_idx + 1;
      if (half_done) half_cnt <= half_cnt + 1;
      if (done) done_cnt <= done_cnt + 1;
      if (err) err_cnt <= err_cnt + 1;
    end
  end

  a_wr_addr: assert property (@(posedge hclk) disable iff (!hrst_n)
    htrans && hready && hwrite |-> haddr == exp_waddr)
    else value_error("haddr_o", $sampled(exp_waddr), $sampled(haddr));
  a_size: assert property (@(posedge hclk) disable iff (!hrst_n)
    htrans |-> hsize == {1'b0, (hwrite ? dst_w : src_w)})
    else value_error("hsize_o", 32'($sampled({1'b0, (hwrite ? dst_w : src_w)})),
                     32'($sampled(hsize)));
  a_hold: assert property (@(posedge hclk) disable iff (!hrst_n)
    htrans && !hready |=> $stable(haddr) && $stable(hwrite))
    else fail_with("haddr_o or hwrite_o changed during a wait state");
  a_grant: assert property (@(posedge hclk) disable iff (!hrst_n) !grant |-> !htrans)
    else fail_with("htrans_o high without grant");
  a_err: assert property (@(posedge hclk) disable iff (!hrst_n) err == (hready && hresp))
    else value_error("err_o", 32'($sampled(hready && hresp)), 32'($sampled(err)));
  a_done_idle: assert property (@(posedge hclk) disable iff (!hrst_n) done |-> !htrans)
    else fail_with("htrans_o high in the done_o cycle");
  a_half_first: assert property (@(posedge hclk) disable iff (!hrst_n) done |-> half_cnt == 1)
    else value_error("half_done_o count at done_o", 32'd1, 32'($sampled(half_cnt)));

  task automatic run_copy(input logic [31:0] s, input logic [31:0] d, input int len,
                          input logic [1:0] sw, input logic [1:0] dw, input logic [1:0] di,
                          input bit jitter, input int exp_err);
    int sb;
    int db;
    int n_wr;
    int wr_seen;
    int waited;
    logic [31:0] a;
    sb = width_bytes(sw);
    db = width_bytes(dw);
    n_wr = len / db;
    for (int k = 0; k < 1024; k++) begin
      mem_i.mem[k] = (k < 512) ? src_byte(k) : ~src_byte(k) ^ 8'h33;
      exp_mem[k] = mem_i.mem[k];
    end
    for (int i = 0; i < len / sb; i++) begin
      a = elem_addr(s, sb, 2'd0, i);
      for (int b = 0; b < sb; b++) stream[i*sb + b] = exp_mem[10'(a + 32'(b))];
    end
    for (int j = 0; j < n_wr; j++) begin
      a = elem_addr(d, db, di, j);
      for (int b = 0; b < db; b++) exp_mem[10'(a + 32'(b))] = stream[j*db + b];
    end
    @(posedge hclk);
    sar <= s;
    dar <= d;
    block_tl <= BLK_W'(len - 1);
    src_w <= sw;
    dst_w <= dw;
    sinc <= 2'd0;
    dinc <= di;
    err_en <= (exp_err != 0);
    clr_cnt <= 1'b1;
    @(posedge hclk);
    clr_cnt <= 1'b0;
    chn_en <= 1'b1;
    grant <= 1'b1;
    wr_seen = 0;
    while (wr_seen < n_wr) begin
      @(negedge hclk);
      if (htrans && hready && hwrite) wr_seen++;
      @(posedge hclk);
      if (wr_seen == n_wr) begin
        chn_en <= 1'b0; // Final write accepted on this edge.
        grant <= 1'b1;
      end else if (jitter) begin
        grant <= ($urandom_range(2) != 0);
      end
    end
    waited = 0;
    do begin
      @(negedge hclk);
      waited++;
    end while (!done && waited < 100);
    if (!done) fail_with("done_o did not follow the final write");
    repeat (3) @(posedge hclk);
    assert (done_cnt == 1) else value_error("done_o count", 32'd1, 32'(done_cnt));
    assert (half_cnt == 1) else value_error("half_done_o count", 32'd1, 32'(half_cnt));
    assert (err_cnt == exp_err) else value_error("err_o count", 32'(exp_err), 32'(err_cnt));
    for (int k = 512; k < 1024; k++) begin
      assert (mem_i.mem[k] == exp_mem[k])
        else value_error($sformatf("mem[%h]", k), 32'(exp_mem[k]), 32'(mem_i.mem[k]));
    end
  endtask

  initial begin
    void'($urandom(11));
    hclk = 1'b0;
    hrst_n = 1'b0;
    chn_en = 1'b0;
    sar = '0;
    dar = '0;
    block_tl = '0;
    src_w = 2'd2;
    dst_w = 2'd2;
    sinc = 2'd0;
    dinc = 2'd0;
    grant = 1'b0;
    err_en = 1'b0;
    clr_cnt = 1'b1;
    repeat (5) @(posedge hclk);
    hrst_n <= 1'b1;
    run_copy(32'h000, 32'h200, 32, 2'd2, 2'd2, 2'd0, 1'b0, 0);
    run_copy(32'h040, 32'h240, 16, 2'd0, 2'd2, 2'd0, 1'b0, 0); // Byte to word.
    run_copy(32'h060, 32'h260, 16, 2'd2, 2'd0, 2'd0, 1'b0, 0); // Word to byte.
    run_copy(32'h080, 32'h280, 24, 2'd1, 2'd2, 2'd0, 1'b0, 0);
    run_copy(32'h0a0, 32'h2c3, 16, 2'd2, 2'd2, 2'd2, 1'b0, 0); // Fixed mode from an unaligned start.
    run_copy(32'h0c0, 32'h3f2, 32, 2'd2, 2'd2, 2'd1, 1'b0, 0); // Decrement.
    run_copy(32'h0e0, 32'h300, 32, 2'd2, 2'd1, 2'd0, 1'b1, 0); // Grant toggling.
    run_copy(32'h000, 32'h340, 16, 2'd2, 2'd2, 2'd0, 1'b0, 1); // Error on 0x008.
    $display("Testbench passed");
    $finish;
  end

  initial begin
    #(WD_CYCLES * 10);
    $display("Watchdog expired before all copies finished");
    $display("Testbench failed");
    $fatal(1);
  end

endmodule

// File: project.f
src/dma_chn_pkg.sv
src/chn_bus_fsm.sv
src/chn_addr_gen.sv
src/chn_data_pack.sv
src/chn_block_cntr.sv
src/dma_chn_top.sv
verification/ahb_mem_model.sv
verification/tb_dma_chn.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dma_chn -f project.f -o sim_dma \
  && { ./obj_dir/sim_dma > sim.log 2>&1 || true; } \
  && cat sim.log \
  && ! grep -q "Testbench failed" sim.log \
  && grep -q "Testbench passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
